/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module rename_stage_tb -Mdir obj_dir -f verilog.f
	@out="$$(./obj_dir/Vrename_stage_tb)"; echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

/* hw/inflight_list.sv */
`timescale 1ns/1ps
`default_nettype none

module inflight_list
  import rename_pkg::*;
#(
  parameter int DISP_SIZE = rename_pkg::DISP_SIZE,
  parameter int WB_PORTS  = rename_pkg::WB_PORTS
) (
  input  wire                         i_clk,
  input  wire                         i_reset_n,
  input  rnid_t   [2*DISP_SIZE-1:0]   i_rnid,
  output logic    [2*DISP_SIZE-1:0]   o_ready,
  input  logic    [DISP_SIZE-1:0]     i_alloc,
  input  rnid_t   [DISP_SIZE-1:0]     i_alloc_rnid,
  input  phy_wr_t [WB_PORTS-1:0]      i_phy_wr
);

  logic [RNID_SIZE-1:0] r_ready;  // 1 = value present in the register file

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ready <= '1;
    end else begin
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (i_alloc[d]) r_ready[i_alloc_rnid[d]] <= 1'b0;
      end
      for (int w = 0; w < WB_PORTS; w++) begin
        if (i_phy_wr[w].valid) r_ready[i_phy_wr[w].rnid] <= 1'b1;
      end
    end
  end

  // writeback in the same cycle is bypassed to the reader
  always_comb begin
    for (int s = 0; s < 2*DISP_SIZE; s++) begin
      o_ready[s] = r_ready[i_rnid[s]] | (i_rnid[s] == '0);
      for (int w = 0; w < WB_PORTS; w++) begin
        if (i_phy_wr[w].valid && i_phy_wr[w].rnid == i_rnid[s]) begin
          o_ready[s] = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/phys_freelist.sv */
`timescale 1ns/1ps
`default_nettype none

module phys_freelist
  import rename_pkg::*;
#(
  parameter int SIZE      = FLIST_SIZE,
  parameter int INIT_BASE = ARCH_REGS
) (
  input  wire   i_clk,
  input  wire   i_reset_n,
  input  logic  i_push,
  input  rnid_t i_push_id,
  input  logic  i_pop,
  output rnid_t o_pop_id,
  output logic  o_empty
);

  localparam int PTR_W = $clog2(SIZE);
  localparam int CNT_W = $clog2(SIZE + 1);

  rnid_t            r_list [SIZE];
  logic [PTR_W-1:0] r_head;   // next rnid handed out
  logic [PTR_W-1:0] r_tail;   // slot for the next release
  logic [CNT_W-1:0] r_count;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(SIZE - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= CNT_W'(SIZE);  // starts full
    end else begin
      if (i_pop) r_head <= ptr_inc(r_head);
      if (i_push) r_tail <= ptr_inc(r_tail);
      case ({i_push, i_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;  // both or neither
      endcase
    end
  end

  // queue body seeded with this lane's block of rnids
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < SIZE; i++) begin
        r_list[i] <= flist_init_id(INIT_BASE, i);
      end
    end else if (i_push) begin
      r_list[r_tail] <= i_push_id;
    end
  end

  assign o_pop_id = r_list[r_head];
  assign o_empty  = (r_count == '0);

endmodule

`default_nettype wire

/* hw/rename_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_dispatch
  import rename_pkg::*;
#(
  parameter int DISP_SIZE = rename_pkg::DISP_SIZE
) (
  input  wire                          i_clk,
  input  wire                          i_reset_n,

  input  logic                         i_disp_valid,
  output logic                         o_disp_ready,
  input  disp_grp_t                    i_disp,

  // free lists, one per lane
  input  logic     [DISP_SIZE-1:0]     i_flist_empty,
  input  rnid_t    [DISP_SIZE-1:0]     i_pop_id,
  output logic     [DISP_SIZE-1:0]     o_pop,

  // map and in-flight lookups
  output arch_id_t [2*DISP_SIZE-1:0]   o_src_id,
  output arch_id_t [DISP_SIZE-1:0]     o_rd_id,
  input  rnid_t    [2*DISP_SIZE-1:0]   i_src_rnid,
  input  rnid_t    [DISP_SIZE-1:0]     i_rd_old_rnid,
  input  logic     [2*DISP_SIZE-1:0]   i_src_ready,

  // map update and in-flight allocation
  output logic     [DISP_SIZE-1:0]     o_update,
  output rnid_t    [DISP_SIZE-1:0]     o_update_rnid,

  output logic                         o_rn_valid,
  output rn_grp_t                      o_rn
);

  logic                 w_fire;
  logic [DISP_SIZE-1:0] w_has_rd;    // lane writes a real destination
  rnid_t [DISP_SIZE-1:0] w_new_rnid;
  rn_grp_t              w_rn;

  // every lane needs an rnid available, whether it uses one or not
  assign o_disp_ready = ~|i_flist_empty;
  assign w_fire       = i_disp_valid & o_disp_ready;

  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_lane
    rnid_t    w_rs1_fwd;
    rnid_t    w_rs2_fwd;
    rnid_t    w_old_fwd;
    logic     w_rs1_hit;
    logic     w_rs2_hit;
    rn_lane_t w_lane;

    assign w_has_rd[d] = i_disp[d].valid & i_disp[d].rd_valid & (i_disp[d].rd_regidx != '0);
    assign w_new_rnid[d] = w_has_rd[d] ? i_pop_id[d] : '0;

    assign o_pop[d]           = w_fire & w_has_rd[d];
    assign o_update[d]        = w_fire & w_has_rd[d];
    assign o_update_rnid[d]   = i_pop_id[d];
    assign o_src_id[2*d]      = i_disp[d].rs1_regidx;
    assign o_src_id[2*d+1]    = i_disp[d].rs2_regidx;
    assign o_rd_id[d]         = i_disp[d].rd_regidx;

    // nearest older lane writing the same register overrides the map
    always_comb begin
      w_rs1_hit = 1'b0;
      w_rs2_hit = 1'b0;
      w_rs1_fwd = i_src_rnid[2*d];
      w_rs2_fwd = i_src_rnid[2*d+1];
      w_old_fwd = i_rd_old_rnid[d];
      for (int p = 0; p < d; p++) begin
        if (w_has_rd[p] && i_disp[p].rd_regidx == i_disp[d].rs1_regidx) begin
          w_rs1_hit = 1'b1;
          w_rs1_fwd = w_new_rnid[p];
        end
        if (w_has_rd[p] && i_disp[p].rd_regidx == i_disp[d].rs2_regidx) begin
          w_rs2_hit = 1'b1;
          w_rs2_fwd = w_new_rnid[p];
        end
        if (w_has_rd[p] && i_disp[p].rd_regidx == i_disp[d].rd_regidx) begin
          w_old_fwd = w_new_rnid[p];
        end
      end
    end

    always_comb begin
      w_lane.valid       = i_disp[d].valid;
      w_lane.rd_rnid     = w_new_rnid[d];  // 0 for x0 or no rd
      w_lane.rd_old_rnid = w_has_rd[d] ? w_old_fwd : '0;
      w_lane.rs1_rnid    = i_disp[d].rs1_valid ? w_rs1_fwd : '0;
      w_lane.rs1_ready   = !i_disp[d].rs1_valid | (!w_rs1_hit & i_src_ready[2*d]);
      w_lane.rs2_rnid    = i_disp[d].rs2_valid ? w_rs2_fwd : '0;
      w_lane.rs2_ready   = !i_disp[d].rs2_valid | (!w_rs2_hit & i_src_ready[2*d+1]);
    end

    assign w_rn[d] = w_lane;
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_rn_valid <= 1'b0;
    end else begin
      o_rn_valid <= w_fire;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_fire) o_rn <= w_rn;
  end

endmodule

`default_nettype wire

/* hw/rename_map.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_map
  import rename_pkg::*;
#(
  parameter int DISP_SIZE = rename_pkg::DISP_SIZE
) (
  input  wire                            i_clk,
  input  wire                            i_reset_n,

  // source lookups, rs1 and rs2 of each lane
  input  arch_id_t [2*DISP_SIZE-1:0]     i_src_id,
  output rnid_t    [2*DISP_SIZE-1:0]     o_src_rnid,

  // destination lookup gives the mapping being replaced
  input  arch_id_t [DISP_SIZE-1:0]       i_rd_id,
  output rnid_t    [DISP_SIZE-1:0]       o_rd_old_rnid,

  input  logic     [DISP_SIZE-1:0]       i_update,
  input  rnid_t    [DISP_SIZE-1:0]       i_update_rnid
);

  rnid_t r_map [ARCH_REGS];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < ARCH_REGS; i++) begin
        r_map[i] <= map_init_id(i);
      end
    end else begin
      // ascending order so the youngest lane lands last
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (i_update[d] && i_rd_id[d] != '0) begin
          r_map[i_rd_id[d]] <= i_update_rnid[d];
        end
      end
    end
  end

  always_comb begin
    for (int s = 0; s < 2*DISP_SIZE; s++) begin
      o_src_rnid[s] = (i_src_id[s] == '0) ? '0 : r_map[i_src_id[s]];  // x0 pinned
    end
  end

  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_rd_old_rnid[d] = (i_rd_id[d] == '0) ? '0 : r_map[i_rd_id[d]];
    end
  end

endmodule

`default_nettype wire

/* hw/rename_pkg.sv */
`default_nettype none

package rename_pkg;

  localparam int ARCH_REGS  = 32;
  localparam int ARCH_W     = 5;
  localparam int DISP_SIZE  = 2;   // lanes per dispatch group
  localparam int FLIST_SIZE = 16;  // entries per lane free list
  localparam int RNID_SIZE  = ARCH_REGS + DISP_SIZE * FLIST_SIZE;
  localparam int RNID_W     = 6;
  localparam int WB_PORTS   = 2;

  typedef logic [ARCH_W-1:0] arch_id_t;
  typedef logic [RNID_W-1:0] rnid_t;

  // one instruction as seen by rename
  typedef struct packed {
    logic     valid;
    logic     rd_valid;
    arch_id_t rd_regidx;
    logic     rs1_valid;
    arch_id_t rs1_regidx;
    logic     rs2_valid;
    arch_id_t rs2_regidx;
  } disp_lane_t;

  typedef disp_lane_t [DISP_SIZE-1:0] disp_grp_t;

  typedef struct packed {
    logic  valid;
    rnid_t rd_rnid;
    rnid_t rd_old_rnid;  // mapping replaced by this rd
    rnid_t rs1_rnid;
    logic  rs1_ready;
    rnid_t rs2_rnid;
    logic  rs2_ready;
  } rn_lane_t;

  typedef rn_lane_t [DISP_SIZE-1:0] rn_grp_t;

  typedef struct packed {
    logic     valid;
    arch_id_t rd_regidx;
    rnid_t    old_rnid;
  } cmt_lane_t;

  typedef cmt_lane_t [DISP_SIZE-1:0] cmt_grp_t;

  typedef struct packed {
    logic  valid;
    rnid_t rnid;
  } phy_wr_t;

  // first rnid owned by the free list of a given lane
  function automatic int unsigned flist_base(int unsigned lane, int unsigned size);
    return ARCH_REGS + lane * size;
  endfunction

  // free list entry idx starts as base + idx, counting upward
  function automatic rnid_t flist_init_id(int unsigned base, int unsigned idx);
    return rnid_t'(base + idx);
  endfunction

  // architectural register i starts mapped to rnid i
  function automatic rnid_t map_init_id(int unsigned idx);
    return rnid_t'(idx);
  endfunction

endpackage

`default_nettype wire

/* hw/rename_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_stage
  import rename_pkg::*;
#(
  parameter int DISP_SIZE  = rename_pkg::DISP_SIZE,
  parameter int FLIST_SIZE = rename_pkg::FLIST_SIZE,
  parameter int WB_PORTS   = rename_pkg::WB_PORTS
) (
  input  wire                       i_clk,
  input  wire                       i_reset_n,

  input  logic                      i_disp_valid,
  output logic                      o_disp_ready,
  input  disp_grp_t                 i_disp,

  output logic                      o_rn_valid,
  output rn_grp_t                   o_rn,

  input  logic                      i_cmt_valid,
  input  cmt_grp_t                  i_cmt,

  input  phy_wr_t [WB_PORTS-1:0]    i_phy_wr
);

  logic     [DISP_SIZE-1:0]   w_flist_empty;
  rnid_t    [DISP_SIZE-1:0]   w_pop_id;
  logic     [DISP_SIZE-1:0]   w_pop;
  logic     [DISP_SIZE-1:0]   w_push;
  arch_id_t [2*DISP_SIZE-1:0] w_src_id;
  arch_id_t [DISP_SIZE-1:0]   w_rd_id;
  rnid_t    [2*DISP_SIZE-1:0] w_src_rnid;
  rnid_t    [DISP_SIZE-1:0]   w_rd_old_rnid;
  logic     [2*DISP_SIZE-1:0] w_src_ready;
  logic     [DISP_SIZE-1:0]   w_update;
  rnid_t    [DISP_SIZE-1:0]   w_update_rnid;

  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_flist
    // committed rd hands its old mapping back to its own lane
    assign w_push[d] = i_cmt_valid & i_cmt[d].valid & (i_cmt[d].rd_regidx != '0);

    phys_freelist #(
      .SIZE      (FLIST_SIZE),
      .INIT_BASE (flist_base(d, FLIST_SIZE))
    ) phys_freelist_i (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_push    (w_push[d]),
      .i_push_id (i_cmt[d].old_rnid),
      .i_pop     (w_pop[d]),
      .o_pop_id  (w_pop_id[d]),
      .o_empty   (w_flist_empty[d])
    );
  end

  rename_dispatch #(
    .DISP_SIZE (DISP_SIZE)
  ) rename_dispatch_i (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_disp_valid  (i_disp_valid),
    .o_disp_ready  (o_disp_ready),
    .i_disp        (i_disp),
    .i_flist_empty (w_flist_empty),
    .i_pop_id      (w_pop_id),
    .o_pop         (w_pop),
    .o_src_id      (w_src_id),
    .o_rd_id       (w_rd_id),
    .i_src_rnid    (w_src_rnid),
    .i_rd_old_rnid (w_rd_old_rnid),
    .i_src_ready   (w_src_ready),
    .o_update      (w_update),
    .o_update_rnid (w_update_rnid),
    .o_rn_valid    (o_rn_valid),
    .o_rn          (o_rn)
  );

  rename_map #(
    .DISP_SIZE (DISP_SIZE)
  ) rename_map_i (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_src_id      (w_src_id),
    .o_src_rnid    (w_src_rnid),
    .i_rd_id       (w_rd_id),
    .o_rd_old_rnid (w_rd_old_rnid),
    .i_update      (w_update),
    .i_update_rnid (w_update_rnid)
  );

  // readiness looked up on the map value; forwarded sources are masked later
  inflight_list #(
    .DISP_SIZE (DISP_SIZE),
    .WB_PORTS  (WB_PORTS)
  ) inflight_list_i (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_rnid       (w_src_rnid),
    .o_ready      (w_src_ready),
    .i_alloc      (w_update),
    .i_alloc_rnid (w_update_rnid),
    .i_phy_wr     (i_phy_wr)
  );

endmodule

`default_nettype wire

/* tb/rename_stage_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_stage_properties #(
  parameter int SIZE = 16
) (
  input wire                      i_clk,
  input wire                      i_reset_n,
  input wire                      i_push,
  input wire                      i_pop,
  input wire                      i_empty,
  input wire [$clog2(SIZE+1)-1:0] i_count
);

  no_pop_when_empty: assert property (
    @(posedge i_clk) disable iff (!i_reset_n) i_pop |-> !i_empty
  ) else $error("free list popped while empty");

  // a release needs a free slot in the queue
  no_push_when_full: assert property (
    @(posedge i_clk) disable iff (!i_reset_n) i_push |-> (i_count < SIZE)
  ) else $error("free list pushed while full");

  count_in_range: assert property (
    @(posedge i_clk) disable iff (!i_reset_n) i_count <= SIZE
  ) else $error("free list occupancy above its size");

endmodule

bind phys_freelist rename_stage_properties #(
  .SIZE (SIZE)
) rename_stage_properties_i (
  .i_clk     (i_clk),
  .i_reset_n (i_reset_n),
  .i_push    (i_push),
  .i_pop     (i_pop),
  .i_empty   (o_empty),
  .i_count   (r_count)
);

`default_nettype wire

/* tb/rename_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_stage_tb
  import rename_pkg::*;
();

  localparam int CYCLE_LIMIT = 5000;  // random groups take about 3 cycles each
  localparam int N_RANDOM    = 300;

  logic                   i_clk;
  logic                   i_reset_n;
  logic                   i_disp_valid;
  logic                   o_disp_ready;
  disp_grp_t              i_disp;
  logic                   o_rn_valid;
  rn_grp_t                o_rn;
  logic                   i_cmt_valid;
  cmt_grp_t               i_cmt;
  phy_wr_t [WB_PORTS-1:0] i_phy_wr;

  // reference model state
  rnid_t                m_map [ARCH_REGS];
  rnid_t                m_free [DISP_SIZE][$];
  rnid_t                m_old [DISP_SIZE][$];  // replaced rnids waiting for commit
  logic [RNID_SIZE-1:0] m_ready;
  logic [RNID_SIZE-1:0] m_pend;                // allocated and not yet written back
  rn_grp_t              exp_q [$];
  logic                 last_fire;             // fire at the coming rising edge
  logic [31:0]          lfsr = 32'h13f7;
  string                test_name = "reset";
  int                   errors = 0;
  int                   checks = 0;
  int                   cycles = 0;

  rename_stage rename_stage_i (.*);

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  function automatic logic rand_bit();
    logic b;
    b = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // taps 32 22 2 1
    lfsr = {lfsr[30:0], b};
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], rand_bit()};
    return v;
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic void model_reset();
    for (int i = 0; i < ARCH_REGS; i++) m_map[i] = rnid_t'(i);
    for (int l = 0; l < DISP_SIZE; l++) begin
      m_free[l].delete();
      m_old[l].delete();
      for (int i = 0; i < FLIST_SIZE; i++) begin
        m_free[l].push_back(rnid_t'(ARCH_REGS + l * FLIST_SIZE + i));
      end
    end
    m_ready   = '1;
    m_pend    = '0;
    last_fire = 1'b0;
    exp_q.delete();
  endfunction

  function automatic logic model_can_fire();
    for (int l = 0; l < DISP_SIZE; l++) if (m_free[l].size() == 0) return 1'b0;
    return 1'b1;
  endfunction

  function automatic logic wb_hit(input rnid_t id);
    for (int w = 0; w < WB_PORTS; w++) begin
      if (i_phy_wr[w].valid && i_phy_wr[w].rnid == id) return 1'b1;
    end
    return 1'b0;
  endfunction

  // nearest older lane with the same rd wins over the map
  function automatic rnid_t src_id(input disp_grp_t g, input logic [DISP_SIZE-1:0] has,
                                   input rnid_t [DISP_SIZE-1:0] fresh, input int l,
                                   input arch_id_t idx);
    rnid_t id;
    id = m_map[idx];
    for (int p = 0; p < l; p++) if (has[p] && g[p].rd_regidx == idx) id = fresh[p];
    return id;
  endfunction

  function automatic logic src_rdy(input disp_grp_t g, input logic [DISP_SIZE-1:0] has,
                                   input int l, input arch_id_t idx);
    for (int p = 0; p < l; p++) if (has[p] && g[p].rd_regidx == idx) return 1'b0;
    return m_ready[m_map[idx]] || wb_hit(m_map[idx]);
  endfunction

  function automatic rn_grp_t rename_ref(input disp_grp_t g);
    rn_grp_t               r;
    logic [DISP_SIZE-1:0]  has;
    rnid_t [DISP_SIZE-1:0] fresh;
    for (int l = 0; l < DISP_SIZE; l++) begin
      has[l]   = g[l].valid && g[l].rd_valid && g[l].rd_regidx != '0;
      fresh[l] = has[l] ? m_free[l][0] : '0;
    end
    for (int l = 0; l < DISP_SIZE; l++) begin
      r[l].valid       = g[l].valid;
      r[l].rd_rnid     = fresh[l];
      r[l].rd_old_rnid = has[l] ? src_id(g, has, fresh, l, g[l].rd_regidx) : '0;
      r[l].rs1_rnid    = g[l].rs1_valid ? src_id(g, has, fresh, l, g[l].rs1_regidx) : '0;
      r[l].rs1_ready   = !g[l].rs1_valid || src_rdy(g, has, l, g[l].rs1_regidx);
      r[l].rs2_rnid    = g[l].rs2_valid ? src_id(g, has, fresh, l, g[l].rs2_regidx) : '0;
      r[l].rs2_ready   = !g[l].rs2_valid || src_rdy(g, has, l, g[l].rs2_regidx);
    end
    return r;
  endfunction

  function automatic void model_step(input disp_grp_t g, input rn_grp_t r, input logic fire);
    for (int l = 0; l < DISP_SIZE; l++) begin
      if (fire && r[l].rd_rnid != '0) begin
        void'(m_free[l].pop_front());
        m_old[l].push_back(r[l].rd_old_rnid);
        m_map[g[l].rd_regidx] = r[l].rd_rnid;  // younger lane written last
        m_ready[r[l].rd_rnid] = 1'b0;
        m_pend[r[l].rd_rnid]  = 1'b1;
      end
      if (i_cmt_valid && i_cmt[l].valid && i_cmt[l].rd_regidx != '0) begin
        m_free[l].push_back(i_cmt[l].old_rnid);
      end
    end
    for (int w = 0; w < WB_PORTS; w++) begin
      if (i_phy_wr[w].valid) begin
        m_ready[i_phy_wr[w].rnid] = 1'b1;
        m_pend[i_phy_wr[w].rnid]  = 1'b0;
      end
    end
  endfunction

  // inputs and outputs are settled at the falling edge
  always @(negedge i_clk) begin
    rn_grp_t r;
    if (i_reset_n) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
        $display("run timed out after %0d cycles", cycles);
        $display("Some tests failed");
        $finish;
      end else begin
        check("rn_valid", 64'(last_fire), 64'(o_rn_valid));
        if (last_fire) check(test_name, 64'(exp_q.pop_front()), 64'(o_rn));
        check("disp_ready", 64'(model_can_fire()), 64'(o_disp_ready));
        last_fire = i_disp_valid && model_can_fire();
        r = last_fire ? rename_ref(i_disp) : '0;
        if (last_fire) exp_q.push_back(r);
        model_step(i_disp, r, last_fire);
      end
    end
  end

  task automatic drive_idle();
    i_disp_valid <= 1'b0;
    i_disp       <= '0;
    i_cmt_valid  <= 1'b0;
    i_cmt        <= '0;
    i_phy_wr     <= '0;
  endtask

  task automatic do_reset();
    i_reset_n <= 1'b0;
    drive_idle();
    repeat (8) @(posedge i_clk);
    model_reset();
    i_reset_n <= 1'b1;
  endtask

  task automatic drive_cmt(input logic [DISP_SIZE-1:0] mask);
    cmt_grp_t c;
    c = '0;
    for (int l = 0; l < DISP_SIZE; l++) begin
      if (mask[l] && m_old[l].size() > 0) begin
        c[l].valid     = 1'b1;
        c[l].rd_regidx = 5'd1;
        c[l].old_rnid  = m_old[l].pop_front();
        m_pend[c[l].old_rnid] = 1'b0;  // released rnid gets no later writeback
      end
    end
    i_cmt_valid <= |mask;
    i_cmt       <= c;
  endtask

  // positive sel writes back that rnid
  // negative sel picks pending rnids at random
  task automatic drive_wb(input int sel);
    phy_wr_t [WB_PORTS-1:0] w;
    int start;
    int port;
    w    = '0;
    port = 0;
    if (sel > 0) begin
      w[0].valid = 1'b1;
      w[0].rnid  = rnid_t'(sel);
    end else if (sel < 0) begin
      start = int'(rand_bits(RNID_W));
      for (int i = 0; i < RNID_SIZE && port < WB_PORTS; i++) begin
        if (m_pend[(start + i) % RNID_SIZE] && rand_bit()) begin
          w[port].valid = 1'b1;
          w[port].rnid  = rnid_t'((start + i) % RNID_SIZE);
          port++;
        end
      end
    end
    i_phy_wr <= w;
  endtask

  task automatic send_group(input disp_grp_t g, input logic [DISP_SIZE-1:0] cmt_mask,
                            input int wb_sel);
    @(posedge i_clk);
    i_disp_valid <= 1'b1;
    i_disp       <= g;
    drive_cmt(cmt_mask);
    drive_wb(wb_sel);
    @(posedge i_clk);
    while (!last_fire) begin
      drive_cmt('1);  // keep releasing while a lane is empty
      @(posedge i_clk);
    end
    drive_idle();
  endtask

  function automatic disp_lane_t make_lane(input logic rdv, input int rd, input logic s1v,
                                           input int rs1, input logic s2v, input int rs2);
    disp_lane_t d;
    d.valid      = 1'b1;
    d.rd_valid   = rdv;
    d.rd_regidx  = arch_id_t'(rd);
    d.rs1_valid  = s1v;
    d.rs1_regidx = arch_id_t'(rs1);
    d.rs2_valid  = s2v;
    d.rs2_regidx = arch_id_t'(rs2);
    return d;
  endfunction

  initial begin
    disp_grp_t                      g;
    logic [$bits(disp_lane_t)-1:0] bits;
    do_reset();
    @(negedge i_clk);
    check("after_reset_valid", 64'(0), 64'(o_rn_valid));
    check("after_reset_ready", 64'(1), 64'(o_disp_ready));

    test_name = "first_group";
    g[0] = make_lane(1, 1, 1, 3, 1, 4);
    g[1] = make_lane(1, 2, 1, 5, 0, 0);
    send_group(g, '0, 0);
    @(negedge i_clk);
    check("first_rd0", 64'(32), 64'(o_rn[0].rd_rnid));
    check("first_rd1", 64'(48), 64'(o_rn[1].rd_rnid));
    check("first_old1", 64'(2), 64'(o_rn[1].rd_old_rnid));
    check("first_rdy", 64'(1), 64'(o_rn[0].rs1_ready & o_rn[0].rs2_ready));

    test_name = "forwarding";
    g[0] = make_lane(1, 7, 1, 1, 0, 0);
    g[1] = make_lane(1, 7, 1, 7, 0, 0);
    send_group(g, '0, 0);
    @(negedge i_clk);
    check("fwd_rs1", 64'(33), 64'(o_rn[1].rs1_rnid));
    check("fwd_rdy", 64'(0), 64'(o_rn[1].rs1_ready));
    check("fwd_old", 64'(33), 64'(o_rn[1].rd_old_rnid));

    test_name = "x0";
    g[0] = make_lane(1, 0, 1, 0, 1, 7);
    g[1] = make_lane(1, 8, 0, 0, 1, 0);
    send_group(g, '0, 0);
    @(negedge i_clk);
    check("x0_rd", 64'(0), 64'(o_rn[0].rd_rnid));
    check("x0_rs1", 64'(0), 64'(o_rn[0].rs1_rnid));
    check("x0_rdy", 64'(1), 64'(o_rn[0].rs1_ready));
    check("x0_map", 64'(49), 64'(o_rn[0].rs2_rnid));  // later group sees lane 1
    check("x0_lane1", 64'(50), 64'(o_rn[1].rd_rnid));

    test_name = "writeback";
    g[0] = make_lane(0, 0, 1, 7, 0, 0);
    g[1] = '0;
    send_group(g, '0, 0);
    @(negedge i_clk);
    check("wb_none", 64'(0), 64'(o_rn[0].rs1_ready));
    send_group(g, '0, 49);  // same cycle as fire
    @(negedge i_clk);
    check("wb_same", 64'(1), 64'(o_rn[0].rs1_ready));
    send_group(g, '0, 0);
    @(negedge i_clk);
    check("wb_early", 64'(1), 64'(o_rn[0].rs1_ready));

    test_name = "exhaustion";
    @(posedge i_clk);
    do_reset();
    for (int i = 0; i < FLIST_SIZE; i++) begin
      g[0] = make_lane(1, i + 1, 0, 0, 0, 0);
      send_group(g, '0, 0);
    end
    @(posedge i_clk);
    i_disp_valid <= 1'b1;
    i_disp       <= g;
    @(negedge i_clk);
    check("exh_ready", 64'(0), 64'(o_disp_ready));
    @(posedge i_clk);
    drive_cmt(2'b01);
    @(posedge i_clk);
    drive_cmt(2'b01);  // second release right behind the first
    @(negedge i_clk);
    check("rel_ready", 64'(1), 64'(o_disp_ready));
    @(posedge i_clk);
    i_cmt_valid <= 1'b0;
    i_cmt       <= '0;
    @(negedge i_clk);
    check("rel_fire", 64'(1), 64'(o_rn_valid));
    check("rel_order0", 64'(1), 64'(o_rn[0].rd_rnid));
    @(posedge i_clk);
    drive_idle();
    @(negedge i_clk);
    check("rel_order1", 64'(2), 64'(o_rn[0].rd_rnid));

    test_name = "random";
    for (int n = 0; n < N_RANDOM; n++) begin
      for (int l = 0; l < DISP_SIZE; l++) begin
        bits       = $bits(disp_lane_t)'(rand_bits($bits(disp_lane_t)));
        g[l]       = bits;
        g[l].valid = (rand_bits(3) != '0);
      end
      send_group(g, DISP_SIZE'(rand_bits(DISP_SIZE)), -1);
    end
    repeat (2) @(negedge i_clk);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
hw/rename_pkg.sv
hw/phys_freelist.sv
hw/rename_map.sv
hw/inflight_list.sv
hw/rename_dispatch.sv
hw/rename_stage.sv
tb/rename_stage_properties.sv
tb/rename_stage_tb.sv
